/* rtl/fetch_pkg.sv */
package fetch_pkg;

    // datapath width, address and instruction alike
    localparam int xlen = 32;

    // first fetch after reset
    localparam logic [xlen-1:0] reset_pc = 32'h1C00_0000;

    // outstanding fetch tracking
    localparam int queue_depth = 4;
    localparam int queue_ptr_w = 2;

    // credit counter, sized to hold the full decode buffer
    localparam int credit_w = 3;
    localparam logic [credit_w-1:0] decode_credits = 3'd4;

    // fetch exception codes
    localparam int excep_w = 2;
    localparam logic [excep_w-1:0] excep_none = 2'd0;
    localparam logic [excep_w-1:0] excep_adef = 2'd1;
    localparam logic [excep_w-1:0] excep_tlbr = 2'd2;

    // direct mapped window, {pseg, vseg}
    localparam int dmw_seg_w = 3;
    localparam logic [2*dmw_seg_w-1:0] dmw_reset = {3'b000, 3'b000};

endpackage

/* rtl/redirect_sel.sv */
module redirect_sel (
    input  logic                       clk,
    input  logic                       resetn,
    input  logic                       br_taken,
    input  logic [fetch_pkg::xlen-1:0] br_target,
    input  logic                       wb_flush,
    input  logic [fetch_pkg::xlen-1:0] wb_target,
    input  logic                       advance,
    output logic [fetch_pkg::xlen-1:0] fetch_va,
    output logic                       redirect
);

    logic [fetch_pkg::xlen-1:0] pc_q;
    logic [fetch_pkg::xlen-1:0] pend_target;
    logic                       pend;

    assign redirect = br_taken | wb_flush;

    // a latched redirect overrides the sequential pc until consumed
    assign fetch_va = pend ? pend_target : pc_q;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            pend <= 1'b0;
            pc_q <= fetch_pkg::reset_pc;
        end else if (redirect) begin
            pend <= 1'b1;
        end else if (advance) begin
            pend <= 1'b0;
            pc_q <= fetch_va + 32'd4;
        end
    end

    // writeback beats branch in the same cycle
    always_ff @(posedge clk) begin
        if (wb_flush) begin
            pend_target <= wb_target;
        end else if (br_taken) begin
            pend_target <= br_target;
        end
    end

endmodule

/* rtl/addr_xlate.sv */
module addr_xlate (
    input  logic                                 clk,
    input  logic                                 resetn,
    input  logic                                 dmw_we,
    input  logic [2*fetch_pkg::dmw_seg_w-1:0]    dmw_wdata,
    input  logic [fetch_pkg::xlen-1:0]           fetch_va,
    output logic [fetch_pkg::xlen-1:0]           fetch_pa,
    output logic [fetch_pkg::excep_w-1:0]        fetch_excep
);

    logic [2*fetch_pkg::dmw_seg_w-1:0] dmw;
    logic [fetch_pkg::dmw_seg_w-1:0]   vseg;
    logic [fetch_pkg::dmw_seg_w-1:0]   pseg;
    logic                              win_hit;
    logic                              misaligned;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            dmw <= fetch_pkg::dmw_reset;
        end else if (dmw_we) begin
            dmw <= dmw_wdata;
        end
    end

    assign vseg = dmw[fetch_pkg::dmw_seg_w-1:0];
    assign pseg = dmw[2*fetch_pkg::dmw_seg_w-1:fetch_pkg::dmw_seg_w];

    // top bits select the segment
    assign win_hit =
        fetch_va[fetch_pkg::xlen-1:fetch_pkg::xlen-fetch_pkg::dmw_seg_w] == vseg;
    assign misaligned = |fetch_va[1:0];

    assign fetch_pa = win_hit ?
        {pseg, fetch_va[fetch_pkg::xlen-fetch_pkg::dmw_seg_w-1:0]} : fetch_va;

    // alignment is checked before the window
    always_comb begin
        if (misaligned) begin
            fetch_excep = fetch_pkg::excep_adef;
        end else if (!win_hit) begin
            fetch_excep = fetch_pkg::excep_tlbr;
        end else begin
            fetch_excep = fetch_pkg::excep_none;
        end
    end

endmodule

/* rtl/fetch_queue.sv */
module fetch_queue (
    input  logic                          clk,
    input  logic                          resetn,
    input  logic                          push,
    input  logic [fetch_pkg::xlen-1:0]    push_pc,
    input  logic [fetch_pkg::excep_w-1:0] push_excep,
    input  logic                          push_mem,
    input  logic                          pop,
    input  logic                          kill_all,
    output logic                          full,
    output logic                          empty,
    output logic                          head_valid,
    output logic [fetch_pkg::xlen-1:0]    head_pc,
    output logic [fetch_pkg::excep_w-1:0] head_excep,
    output logic                          head_killed,
    output logic                          head_mem
);

    logic [fetch_pkg::xlen-1:0]    pc_mem    [fetch_pkg::queue_depth];
    logic [fetch_pkg::excep_w-1:0] excep_mem [fetch_pkg::queue_depth];
    logic                          mem_flag  [fetch_pkg::queue_depth];
    logic [fetch_pkg::queue_depth-1:0] killed;
    logic [fetch_pkg::queue_ptr_w-1:0] wr_ptr;
    logic [fetch_pkg::queue_ptr_w-1:0] rd_ptr;
    logic [fetch_pkg::queue_ptr_w:0]   count;

    assign full       = count == fetch_pkg::queue_depth;
    assign empty      = count == '0;
    assign head_valid = !empty;

    assign head_pc     = pc_mem[rd_ptr];
    assign head_excep  = excep_mem[rd_ptr];
    assign head_mem    = mem_flag[rd_ptr];
    assign head_killed = killed[rd_ptr];

    // pointers wrap naturally, depth is a power of two
    always_ff @(posedge clk) begin
        if (!resetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // kill marks everything stored, plus a same-cycle push
    always_ff @(posedge clk) begin
        if (!resetn) begin
            killed <= '0;
        end else begin
            if (kill_all) begin
                killed <= '1;
            end
            if (push) begin
                killed[wr_ptr] <= kill_all;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            pc_mem[wr_ptr]    <= push_pc;
            excep_mem[wr_ptr] <= push_excep;
            mem_flag[wr_ptr]  <= push_mem;
        end
    end

endmodule

/* rtl/fetch_ctrl.sv */
module fetch_ctrl (
    input  logic                          clk,
    input  logic                          resetn,
    input  logic [fetch_pkg::xlen-1:0]    fetch_va,
    input  logic [fetch_pkg::xlen-1:0]    fetch_pa,
    input  logic [fetch_pkg::excep_w-1:0] fetch_excep,
    input  logic                          redirect,
    input  logic                          inst_addr_ok,
    input  logic                          inst_data_ok,
    input  logic [fetch_pkg::xlen-1:0]    inst_rdata,
    input  logic                          fe_credit,
    input  logic                          full,
    input  logic                          empty,
    input  logic                          head_valid,
    input  logic [fetch_pkg::xlen-1:0]    head_pc,
    input  logic [fetch_pkg::excep_w-1:0] head_excep,
    input  logic                          head_killed,
    input  logic                          head_mem,
    output logic                          advance,
    output logic                          push,
    output logic [fetch_pkg::xlen-1:0]    push_pc,
    output logic [fetch_pkg::excep_w-1:0] push_excep,
    output logic                          push_mem,
    output logic                          pop,
    output logic                          kill_all,
    output logic                          inst_req,
    output logic [fetch_pkg::xlen-1:0]    inst_addr,
    output logic                          fe_valid,
    output logic [fetch_pkg::xlen-1:0]    fe_pc,
    output logic [fetch_pkg::xlen-1:0]    fe_inst,
    output logic [fetch_pkg::excep_w-1:0] fe_excep
);

    logic [fetch_pkg::credit_w-1:0] credits;
    logic [fetch_pkg::credit_w-1:0] credit_take;
    logic [fetch_pkg::credit_w-1:0] credit_ret;
    logic [fetch_pkg::credit_w-1:0] credit_kill;
    logic [fetch_pkg::xlen-1:0]     req_pc;
    logic                           req_stale;
    logic                           halted;
    logic                           accept;
    logic                           fault;
    logic                           slot_ok;
    logic                           issue;
    logic                           exc_push;
    logic                           head_out;
    logic                           kill_ret;

    assign accept = inst_req & inst_addr_ok;
    assign fault  = fetch_excep != fetch_pkg::excep_none;

    // one request register, refilled only once it has gone out
    assign slot_ok  = !inst_req && !halted && !redirect && credits != '0;
    assign issue    = slot_ok && !full && !fault;
    // faults wait for an empty queue so they never race data_ok
    assign exc_push = slot_ok && empty && fault;

    // a stale request no longer owns fetch_va
    assign advance  = (accept & ~req_stale) | exc_push;
    assign kill_all = redirect | (accept & req_stale);

    assign push       = accept | exc_push;
    assign push_pc    = accept ? req_pc : fetch_va;
    assign push_excep = accept ? fetch_pkg::excep_none : fetch_excep;
    assign push_mem   = accept;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            inst_req <= 1'b0;
        end else if (issue) begin
            inst_req <= 1'b1;
        end else if (accept) begin
            inst_req <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            inst_addr <= fetch_pa;
            req_pc    <= fetch_va;
        end
    end

    // redirect while the request waits for addr_ok
    always_ff @(posedge clk) begin
        if (!resetn) begin
            req_stale <= 1'b0;
        end else if (accept) begin
            req_stale <= 1'b0;
        end else if (redirect && inst_req) begin
            req_stale <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            halted <= 1'b0;
        end else if (redirect) begin
            halted <= 1'b0;
        end else if (exc_push) begin
            halted <= 1'b1;
        end
    end

    // head leaves on its data, or at once when it is an exception
    assign head_out = head_valid && (head_mem ? inst_data_ok : 1'b1);
    assign pop      = head_out;
    assign kill_ret = head_out & head_killed;

    assign fe_valid = head_out & ~head_killed;
    assign fe_pc    = head_pc;
    assign fe_inst  = head_mem ? inst_rdata : '0;
    assign fe_excep = head_excep;

    assign credit_take = {{(fetch_pkg::credit_w-1){1'b0}}, issue | exc_push};
    assign credit_ret  = {{(fetch_pkg::credit_w-1){1'b0}}, fe_credit};
    assign credit_kill = {{(fetch_pkg::credit_w-1){1'b0}}, kill_ret};

    always_ff @(posedge clk) begin
        if (!resetn) begin
            credits <= fetch_pkg::decode_credits;
        end else begin
            credits <= credits - credit_take + credit_ret + credit_kill;
        end
    end

endmodule

/* rtl/fetch_top.sv */
module fetch_top (
    input  logic                              clk,
    input  logic                              resetn,
    output logic                              inst_req,
    output logic [fetch_pkg::xlen-1:0]        inst_addr,
    input  logic                              inst_addr_ok,
    input  logic                              inst_data_ok,
    input  logic [fetch_pkg::xlen-1:0]        inst_rdata,
    input  logic                              br_taken,
    input  logic [fetch_pkg::xlen-1:0]        br_target,
    input  logic                              wb_flush,
    input  logic [fetch_pkg::xlen-1:0]        wb_target,
    input  logic                              dmw_we,
    input  logic [2*fetch_pkg::dmw_seg_w-1:0] dmw_wdata,
    output logic                              fe_valid,
    output logic [fetch_pkg::xlen-1:0]        fe_pc,
    output logic [fetch_pkg::xlen-1:0]        fe_inst,
    output logic [fetch_pkg::excep_w-1:0]     fe_excep,
    input  logic                              fe_credit
);

    logic                          advance;
    logic                          redirect;
    logic [fetch_pkg::xlen-1:0]    fetch_va;
    logic [fetch_pkg::xlen-1:0]    fetch_pa;
    logic [fetch_pkg::excep_w-1:0] fetch_excep;
    logic                          push;
    logic [fetch_pkg::xlen-1:0]    push_pc;
    logic [fetch_pkg::excep_w-1:0] push_excep;
    logic                          push_mem;
    logic                          pop;
    logic                          kill_all;
    logic                          full;
    logic                          empty;
    logic                          head_valid;
    logic [fetch_pkg::xlen-1:0]    head_pc;
    logic [fetch_pkg::excep_w-1:0] head_excep;
    logic                          head_killed;
    logic                          head_mem;

    redirect_sel u_redirect_sel (
        .clk       (clk),
        .resetn    (resetn),
        .br_taken  (br_taken),
        .br_target (br_target),
        .wb_flush  (wb_flush),
        .wb_target (wb_target),
        .advance   (advance),
        .fetch_va  (fetch_va),
        .redirect  (redirect)
    );

    addr_xlate u_addr_xlate (
        .clk         (clk),
        .resetn      (resetn),
        .dmw_we      (dmw_we),
        .dmw_wdata   (dmw_wdata),
        .fetch_va    (fetch_va),
        .fetch_pa    (fetch_pa),
        .fetch_excep (fetch_excep)
    );

    fetch_queue u_fetch_queue (
        .clk         (clk),
        .resetn      (resetn),
        .push        (push),
        .push_pc     (push_pc),
        .push_excep  (push_excep),
        .push_mem    (push_mem),
        .pop         (pop),
        .kill_all    (kill_all),
        .full        (full),
        .empty       (empty),
        .head_valid  (head_valid),
        .head_pc     (head_pc),
        .head_excep  (head_excep),
        .head_killed (head_killed),
        .head_mem    (head_mem)
    );

    fetch_ctrl u_fetch_ctrl (
        .clk          (clk),
        .resetn       (resetn),
        .fetch_va     (fetch_va),
        .fetch_pa     (fetch_pa),
        .fetch_excep  (fetch_excep),
        .redirect     (redirect),
        .inst_addr_ok (inst_addr_ok),
        .inst_data_ok (inst_data_ok),
        .inst_rdata   (inst_rdata),
        .fe_credit    (fe_credit),
        .full         (full),
        .empty        (empty),
        .head_valid   (head_valid),
        .head_pc      (head_pc),
        .head_excep   (head_excep),
        .head_killed  (head_killed),
        .head_mem     (head_mem),
        .advance      (advance),
        .push         (push),
        .push_pc      (push_pc),
        .push_excep   (push_excep),
        .push_mem     (push_mem),
        .pop          (pop),
        .kill_all     (kill_all),
        .inst_req     (inst_req),
        .inst_addr    (inst_addr),
        .fe_valid     (fe_valid),
        .fe_pc        (fe_pc),
        .fe_inst      (fe_inst),
        .fe_excep     (fe_excep)
    );

endmodule

/* tests/inst_mem_model.sv */
module inst_mem_model (
    input  logic                       clk,
    input  logic                       resetn,
    input  logic                       inst_req,
    input  logic [fetch_pkg::xlen-1:0] inst_addr,
    output logic                       inst_addr_ok,
    output logic                       inst_data_ok,
    output logic [fetch_pkg::xlen-1:0] inst_rdata
);

    // each word is its physical address with a fixed tag
    localparam logic [fetch_pkg::xlen-1:0] data_tag = 32'h5A5A_0000;

    integer                     seed;
    int                         aok_wait;
    logic                       accepted;
    logic [fetch_pkg::xlen-1:0] acc_addr;
    logic [fetch_pkg::xlen-1:0] data_q[$];
    int                         lat_q[$];

    initial begin
        seed         = 32'haa708884;
        aok_wait     = -1;
        inst_addr_ok = 1'b0;
        inst_data_ok = 1'b0;
        inst_rdata   = '0;
    end

    always @(posedge clk) begin
        accepted = inst_req && inst_addr_ok;
        acc_addr = inst_addr;
        #1;
        inst_addr_ok = 1'b0;
        inst_data_ok = 1'b0;
        inst_rdata   = '0;
        if (!resetn) begin
            aok_wait = -1;
            data_q.delete();
            lat_q.delete();
        end else begin
            if (accepted) begin
                aok_wait = -1;
                data_q.push_back(acc_addr ^ data_tag);
                lat_q.push_back(1 + $unsigned($random(seed)) % 3);
            end
            // address phase waits 0 to 2 cycles
            if (inst_req) begin
                if (aok_wait < 0) begin
                    aok_wait = $unsigned($random(seed)) % 3;
                end
                if (aok_wait == 0) begin
                    inst_addr_ok = 1'b1;
                end else begin
                    aok_wait = aok_wait - 1;
                end
            end
            // responses in request order, at most one per cycle
            if (lat_q.size() > 0) begin
                lat_q[0] = lat_q[0] - 1;
                if (lat_q[0] == 0) begin
                    inst_data_ok = 1'b1;
                    inst_rdata   = data_q.pop_front();
                    void'(lat_q.pop_front());
                end
            end
        end
    end

endmodule

/* tests/tb_fetch_top.sv */
module tb_fetch_top;

    localparam logic [fetch_pkg::xlen-1:0] data_tag = 32'h5A5A_0000;
    localparam int low_w = fetch_pkg::xlen - fetch_pkg::dmw_seg_w;
    // about six times the summed length of the directed tests
    localparam int max_cycles = 2000;

    logic                              clk;
    logic                              resetn;
    logic                              inst_req;
    logic [fetch_pkg::xlen-1:0]        inst_addr;
    logic                              inst_addr_ok;
    logic                              inst_data_ok;
    logic [fetch_pkg::xlen-1:0]        inst_rdata;
    logic                              br_taken;
    logic [fetch_pkg::xlen-1:0]        br_target;
    logic                              wb_flush;
    logic [fetch_pkg::xlen-1:0]        wb_target;
    logic                              dmw_we;
    logic [2*fetch_pkg::dmw_seg_w-1:0] dmw_wdata;
    logic                              fe_valid;
    logic [fetch_pkg::xlen-1:0]        fe_pc;
    logic [fetch_pkg::xlen-1:0]        fe_inst;
    logic [fetch_pkg::excep_w-1:0]     fe_excep;
    logic                              fe_credit;

    logic [fetch_pkg::xlen-1:0]    got_pc[$];
    logic [fetch_pkg::xlen-1:0]    got_inst[$];
    logic [fetch_pkg::excep_w-1:0] got_excep[$];
    int                            errors;
    int                            tests;
    int                            cycles;
    int                            owed;
    logic                          hold;
    logic                          cr_d1;
    logic                          v_seen;
    logic                          h_seen;
    logic                          req_d;
    logic                          aok_d;
    logic [fetch_pkg::xlen-1:0]    addr_d;

    fetch_top uut (.*);

    inst_mem_model u_mem (.*);

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= max_cycles) begin
            $display("timeout: run stopped after %0d cycles", cycles);
            $display("Errors found");
            $finish;
        end
    end

    // record everything decode receives
    always @(posedge clk) begin
        if (resetn && fe_valid) begin
            got_pc.push_back(fe_pc);
            got_inst.push_back(fe_inst);
            got_excep.push_back(fe_excep);
        end
    end

    // a request waiting for addr_ok keeps its address
    always @(posedge clk) begin
        if (resetn && req_d && !aok_d) begin
            if (inst_req !== 1'b1) begin
                $display("%0t: inst_req dropped before the request was accepted", $time);
                errors = errors + 1;
            end else if (inst_addr !== addr_d) begin
                report_mismatch("inst_addr", addr_d, inst_addr);
            end
        end
        req_d  = resetn && inst_req;
        aok_d  = inst_addr_ok;
        addr_d = inst_addr;
    end

    // decode frees a slot two cycles after fe_valid, held credits are owed
    always @(posedge clk) begin
        v_seen = resetn && fe_valid;
        h_seen = hold;
        #1;
        if (cr_d1) begin
            fe_credit = 1'b1;
        end else if (owed > 0 && !h_seen) begin
            fe_credit = 1'b1;
            owed      = owed - 1;
        end else begin
            fe_credit = 1'b0;
        end
        cr_d1 = v_seen && !h_seen;
        if (v_seen && h_seen) begin
            owed = owed + 1;
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic wait_entries(input int n);
        while (got_pc.size() < n) begin
            next_cycle();
        end
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] got);
        $display("ERROR %0t %s expected %h got %h", $time, name, exp, got);
        errors = errors + 1;
    endtask

    task automatic finish_test(input string name, input int err0);
        tests = tests + 1;
        $display("test %0d %s finished with %0d errors", tests, name, errors - err0);
    endtask

    task automatic send_redirect(input logic br, input logic [31:0] bt,
                                 input logic wb, input logic [31:0] wt);
        br_taken  = br;
        br_target = bt;
        wb_flush  = wb;
        wb_target = wt;
        next_cycle();
        br_taken = 1'b0;
        wb_flush = 1'b0;
        got_pc.delete();
        got_inst.delete();
        got_excep.delete();
    endtask

    // entry i of a sequential run starts at base + 4*i
    task automatic check_run(input int first, input int last, input logic [31:0] base,
                             input logic [fetch_pkg::dmw_seg_w-1:0] pseg);
        int          i;
        logic [31:0] pc;
        logic [31:0] inst;
        for (i = first; i < last; i++) begin
            pc   = base + 32'(4 * i);
            inst = {pseg, pc[low_w-1:0]} ^ data_tag;
            if (got_pc[i] !== pc) begin
                report_mismatch($sformatf("fe_pc[%0d]", i), pc, got_pc[i]);
            end
            if (got_inst[i] !== inst) begin
                report_mismatch($sformatf("fe_inst[%0d]", i), inst, got_inst[i]);
            end
            if (got_excep[i] !== fetch_pkg::excep_none) begin
                report_mismatch($sformatf("fe_excep[%0d]", i), fetch_pkg::excep_none,
                                got_excep[i]);
            end
        end
    endtask

    task automatic sequential_after_reset();
        int err0;
        err0 = errors;
        wait_entries(10);
        check_run(0, 10, fetch_pkg::reset_pc, 3'b000);
        finish_test("sequential fetch after reset", err0);
    endtask

    task automatic credit_backpressure();
        int err0;
        int n0;
        int seen;
        err0 = errors;
        n0   = got_pc.size();
        hold = 1'b1;
        repeat (40) next_cycle();
        seen = got_pc.size() - n0;
        if (seen > fetch_pkg::decode_credits) begin
            $display("%0t: %0d entries reached decode with credits withheld, limit is %0d",
                     $time, seen, fetch_pkg::decode_credits);
            errors = errors + 1;
        end
        // every credit is spent by now
        if (inst_req !== 1'b0) begin
            report_mismatch("inst_req", 32'd0, {31'd0, inst_req});
        end
        hold = 1'b0;
        wait_entries(n0 + seen + 4);
        check_run(n0, got_pc.size(), fetch_pkg::reset_pc, 3'b000);
        finish_test("credit back-pressure", err0);
    endtask

    task automatic branch_redirect();
        int err0;
        err0 = errors;
        send_redirect(1'b1, 32'h0000_1000, 1'b0, '0);
        wait_entries(6);
        check_run(0, 6, 32'h0000_1000, 3'b000);
        finish_test("branch redirect", err0);
    endtask

    task automatic writeback_priority();
        int err0;
        err0 = errors;
        send_redirect(1'b1, 32'h0000_2000, 1'b1, 32'h0000_3000);
        wait_entries(4);
        check_run(0, 4, 32'h0000_3000, 3'b000);
        finish_test("writeback over branch", err0);
    endtask

    task automatic misaligned_halt();
        int err0;
        err0 = errors;
        send_redirect(1'b1, 32'h0000_4002, 1'b0, '0);
        wait_entries(1);
        repeat (30) next_cycle();
        if (got_pc.size() != 1) begin
            $display("%0t: fetch did not halt, %0d entries after a misaligned redirect",
                     $time, got_pc.size());
            errors = errors + 1;
        end
        if (got_pc[0] !== 32'h0000_4002) begin
            report_mismatch("fe_pc", 32'h0000_4002, got_pc[0]);
        end
        if (got_excep[0] !== fetch_pkg::excep_adef) begin
            report_mismatch("fe_excep", fetch_pkg::excep_adef, got_excep[0]);
        end
        finish_test("misaligned fetch", err0);
    endtask

    task automatic window_remap();
        int err0;
        err0 = errors;
        send_redirect(1'b1, 32'h4000_1000, 1'b0, '0);
        wait_entries(1);
        if (got_excep[0] !== fetch_pkg::excep_tlbr) begin
            report_mismatch("fe_excep", fetch_pkg::excep_tlbr, got_excep[0]);
        end
        // map virtual segment 3'b010 onto physical 3'b001
        dmw_we    = 1'b1;
        dmw_wdata = {3'b001, 3'b010};
        next_cycle();
        dmw_we = 1'b0;
        send_redirect(1'b1, 32'h4000_2000, 1'b0, '0);
        wait_entries(4);
        check_run(0, 4, 32'h4000_2000, 3'b001);
        finish_test("window miss and remap", err0);
    endtask

    initial begin
        clk       = 1'b0;
        resetn    = 1'b0;
        br_taken  = 1'b0;
        br_target = '0;
        wb_flush  = 1'b0;
        wb_target = '0;
        dmw_we    = 1'b0;
        dmw_wdata = '0;
        fe_credit = 1'b0;
        hold      = 1'b0;
        cr_d1     = 1'b0;
        req_d     = 1'b0;
        aok_d     = 1'b0;
        addr_d    = '0;
        owed      = 0;
        errors    = 0;
        tests     = 0;
        cycles    = 0;
        repeat (5) @(posedge clk);
        #1;
        resetn = 1'b1;
        sequential_after_reset();
        credit_backpressure();
        branch_redirect();
        writeback_priority();
        misaligned_halt();
        window_remap();
        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* project.f */
rtl/fetch_pkg.sv
rtl/redirect_sel.sv
rtl/addr_xlate.sv
rtl/fetch_queue.sv
rtl/fetch_ctrl.sv
rtl/fetch_top.sv
tests/inst_mem_model.sv
tests/tb_fetch_top.sv

/* Bender.yml */
package:
  name: fetch_front_end

sources:
  - rtl/fetch_pkg.sv
  - rtl/redirect_sel.sv
  - rtl/addr_xlate.sv
  - rtl/fetch_queue.sv
  - rtl/fetch_ctrl.sv
  - rtl/fetch_top.sv
  - target: test
    files:
      - tests/inst_mem_model.sv
      - tests/tb_fetch_top.sv
